//--- verilog/sensor_pkg.sv
package sensor_pkg;

	typedef logic [2:0] sensor_id_t;	// 0-3 temperature, 4-7 light

	localparam int NUM_SENSORS = 8;

	// Solar, greenhouse, ambient, geothermal, then north, east, south, west
	localparam logic [6:0] SENSOR_ADDR [NUM_SENSORS] = '{
		7'h48, 7'h49, 7'h4a, 7'h4b,
		7'h44, 7'h45, 7'h46, 7'h47
	};

	typedef struct packed {
		logic signed [8:0] celsius;	// Whole degrees
		logic [6:0]        unused;
	} temp_view_t;

	typedef struct packed {
		logic [3:0]  exponent;
		logic [11:0] fraction;
	} light_view_t;

	typedef union packed {
		temp_view_t  temp;
		light_view_t light;
	} raw_sample_t;

	typedef struct packed {
		sensor_id_t  id;
		raw_sample_t raw;
	} sample_t;

	function automatic logic is_light(sensor_id_t id);
		return id[2];
	endfunction

	// Lux is fraction * 2^exponent / 100, truncated, clipped to 16 bits
	function automatic logic [15:0] lux_of(raw_sample_t raw);
		logic [27:0] scaled;
		logic [27:0] lux;
		scaled = 28'(raw.light.fraction) << raw.light.exponent;
		lux = scaled / 28'd100;
		return (lux > 28'd65535) ? 16'hffff : lux[15:0];
	endfunction

endpackage

//--- verilog/i2c_req_if.sv
`timescale 1ns/1ps

interface i2c_req_if;
	logic        start;	// One-cycle request pulse
	logic [6:0]  addr;
	logic        ready;	// Engine idle, results valid
	logic [15:0] read_data;
	logic        ack;	// Target acknowledged its address

	modport sequencer (
		output start, addr,
		input  ready, read_data, ack
	);

	modport master (
		input  start, addr,
		output ready, read_data, ack
	);
endinterface

//--- verilog/poll_sequencer.sv
`timescale 1ns/1ps

module poll_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                full,
	output logic                push,
	output sensor_pkg::sample_t push_data,
	i2c_req_if.sequencer        bus
);
	import sensor_pkg::*;

	sensor_id_t idx;	// Sensor being read
	logic       busy;	// Read outstanding on the bus
	logic       need;	// Next read waits to be issued
	logic       done;

	assign done = busy && bus.ready;

	assign bus.start = need && !full;	// Held off while FIFO is full
	assign bus.addr  = SENSOR_ADDR[idx];

	assign push          = done && bus.ack;	// NACKed sensors are skipped
	assign push_data.id  = idx;
	assign push_data.raw = bus.read_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idx  <= '0;
			busy <= 1'b0;
			need <= 1'b0;
		end
		else if (bus.start)
		begin
			busy <= 1'b1;
			need <= 1'b0;
		end
		else if (done)
		begin
			busy <= 1'b0;
			need <= 1'b1;
			idx  <= (idx == sensor_id_t'(NUM_SENSORS - 1)) ? '0 : idx + 1'b1;
		end
		else if (!busy && !need)
		begin
			need <= 1'b1;	// First read after reset
		end
	end

	// The decoder drains faster than reads complete, so the FIFO never overflows
	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (rst)
		push |-> !full
	) else $error("poll_sequencer pushed into a full FIFO");

endmodule

//--- verilog/i2c_master.sv
`timescale 1ns/1ps

module i2c_master #(
	parameter int CLK_DIV = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      sda_in,
	output logic      scl,
	output logic      sda_oe,
	i2c_req_if.master bus
);
	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	typedef enum logic [2:0] {
		P_IDLE,
		P_START,
		P_ADDR,
		P_ADDR_ACK,
		P_DATA,
		P_MACK,
		P_STOP
	} phase_t;

	phase_t      phase;
	logic [DIV_W-1:0] div_cnt;
	logic        half;	// 0 is the SCL low half of a bit
	logic [3:0]  bit_cnt;
	logic        tick;
	logic        bit_end;
	logic        ack;
	logic [7:0]  tx_byte;
	logic [15:0] rx_data;

	assign tick    = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign bit_end = tick && half;

	assign bus.ready     = (phase == P_IDLE);
	assign bus.read_data = rx_data;
	assign bus.ack       = ack;

	// Bus pins decoded from the phase and half-bit
	always_comb
	begin
		scl    = 1'b1;
		sda_oe = 1'b0;
		case (phase)
			P_IDLE:     scl = 1'b1;
			P_START:
			begin
				scl    = ~half;	// SDA falls first, then SCL
				sda_oe = 1'b1;
			end
			P_ADDR:
			begin
				scl    = half;
				sda_oe = ~tx_byte[7];
			end
			P_ADDR_ACK: scl = half;
			P_DATA:     scl = half;
			P_MACK:
			begin
				scl    = half;
				sda_oe = bit_cnt[3];	// ACK after byte one, NACK after byte two
			end
			P_STOP:
			begin
				scl    = half;
				sda_oe = 1'b1;	// Released on return to idle
			end
			default:    scl = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase   <= P_IDLE;
			div_cnt <= '0;
			half    <= 1'b0;
			bit_cnt <= '0;
			ack     <= 1'b0;
		end
		else if (phase == P_IDLE)
		begin
			div_cnt <= '0;
			half    <= 1'b0;
			bit_cnt <= '0;
			if (bus.start)
				phase <= P_START;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				half <= ~half;
			if (bit_end)
			begin
				case (phase)
					P_START:    phase <= P_ADDR;
					P_ADDR:
					begin
						bit_cnt <= (bit_cnt == 4'd7) ? 4'd0 : bit_cnt + 1'b1;
						if (bit_cnt == 4'd7)
							phase <= P_ADDR_ACK;
					end
					P_ADDR_ACK:
					begin
						ack   <= ~sda_in;
						phase <= sda_in ? P_STOP : P_DATA;	// Give up on NACK
					end
					P_DATA:
					begin
						bit_cnt <= bit_cnt + 1'b1;	// Wraps to 0 after byte two
						if (bit_cnt[2:0] == 3'd7)
							phase <= P_MACK;
					end
					P_MACK:     phase <= bit_cnt[3] ? P_DATA : P_STOP;
					P_STOP:     phase <= P_IDLE;
					default:    phase <= P_IDLE;
				endcase
			end
		end
	end

	// Address shifter and receive register
	always_ff @(posedge clk)
	begin
		if (phase == P_IDLE && bus.start)
			tx_byte <= {bus.addr, 1'b1};	// Read bit set
		else if (phase == P_ADDR && bit_end)
			tx_byte <= {tx_byte[6:0], 1'b0};
		if (phase == P_DATA && bit_end)
			rx_data <= {rx_data[14:0], sda_in};	// MSB first
	end

	a_start_when_ready: assert property (
		@(posedge clk) disable iff (rst)
		bus.start |-> bus.ready
	) else $error("i2c_master got start while busy");

	// Only START and STOP may move SDA under a high SCL
	a_sda_stable_scl_high: assert property (
		@(posedge clk) disable iff (rst)
		(scl && $past(scl) && phase != P_START && $past(phase) != P_STOP)
			|-> $stable(sda_oe)
	) else $error("i2c_master moved SDA while SCL high");

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  sensor_pkg::sample_t push_data,
	input  logic                pop,
	output logic                full,
	output logic                valid,
	output sensor_pkg::sample_t pop_data
);
	import sensor_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	sample_t       mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign full     = (count == (AW + 1)'(FIFO_DEPTH));
	assign valid    = (count != '0);
	assign pop_data = mem[rd_ptr];
	assign do_push  = push && !full;
	assign do_pop   = pop && valid;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// Depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst)
		push |-> !full
	) else $error("sample_fifo overflow");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (rst)
		pop |-> valid
	) else $error("sample_fifo underflow");

endmodule

//--- verilog/reading_decoder.sv
`timescale 1ns/1ps

module reading_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  sensor_pkg::sample_t pop_data,
	output logic                pop,
	output logic signed [8:0]   solar_celsius,
	output logic signed [8:0]   greenhouse_celsius,
	output logic signed [8:0]   ambient_celsius,
	output logic signed [8:0]   geothermal_celsius,
	output logic [15:0]         north_lux,
	output logic [15:0]         east_lux,
	output logic [15:0]         south_lux,
	output logic [15:0]         west_lux
);
	import sensor_pkg::*;

	logic              s1_valid;
	sample_t           s1_sample;
	logic signed [8:0] celsius_q [4];	// Indexed by id[1:0]
	logic [15:0]       lux_q [4];

	assign pop = valid;	// Drain whenever a sample waits

	// Stage one
	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= valid;
	end

	always_ff @(posedge clk)
	begin
		if (valid)
			s1_sample <= pop_data;
	end

	// Stage two converts and writes the sensor's register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 4; i++)
			begin
				celsius_q[i] <= '0;
				lux_q[i]     <= '0;
			end
		end
		else if (s1_valid)
		begin
			if (is_light(s1_sample.id))
				lux_q[s1_sample.id[1:0]] <= lux_of(s1_sample.raw);
			else
				celsius_q[s1_sample.id[1:0]] <= s1_sample.raw.temp.celsius;
		end
	end

	assign solar_celsius      = celsius_q[0];
	assign greenhouse_celsius = celsius_q[1];
	assign ambient_celsius    = celsius_q[2];
	assign geothermal_celsius = celsius_q[3];
	assign north_lux          = lux_q[0];
	assign east_lux           = lux_q[1];
	assign south_lux          = lux_q[2];
	assign west_lux           = lux_q[3];

endmodule

//--- verilog/sensor_hub.sv
`timescale 1ns/1ps

module sensor_hub #(
	parameter int CLK_DIV    = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              sda_in,
	output logic              scl,
	output logic              sda_oe,	// High pulls SDA low
	output logic signed [8:0] solar_celsius,
	output logic signed [8:0] greenhouse_celsius,
	output logic signed [8:0] ambient_celsius,
	output logic signed [8:0] geothermal_celsius,
	output logic [15:0]       north_lux,
	output logic [15:0]       east_lux,
	output logic [15:0]       south_lux,
	output logic [15:0]       west_lux
);
	import sensor_pkg::*;

	logic    push;
	sample_t push_data;
	logic    full;
	logic    valid;
	sample_t pop_data;
	logic    pop;

	i2c_req_if req_bus ();

	poll_sequencer poll_sequencer_i (
		.clk       (clk),
		.rst       (rst),
		.full      (full),
		.push      (push),
		.push_data (push_data),
		.bus       (req_bus.sequencer)
	);

	i2c_master #(
		.CLK_DIV (CLK_DIV)
	) i2c_master_i (
		.clk    (clk),
		.rst    (rst),
		.sda_in (sda_in),
		.scl    (scl),
		.sda_oe (sda_oe),
		.bus    (req_bus.master)
	);

	sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) sample_fifo_i (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.full      (full),
		.valid     (valid),
		.pop_data  (pop_data)
	);

	reading_decoder reading_decoder_i (
		.clk                (clk),
		.rst                (rst),
		.valid              (valid),
		.pop_data           (pop_data),
		.pop                (pop),
		.solar_celsius      (solar_celsius),
		.greenhouse_celsius (greenhouse_celsius),
		.ambient_celsius    (ambient_celsius),
		.geothermal_celsius (geothermal_celsius),
		.north_lux          (north_lux),
		.east_lux           (east_lux),
		.south_lux          (south_lux),
		.west_lux           (west_lux)
	);

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;	// Released on a falling edge
	end
endmodule

//--- tb/i2c_sensor_model.sv
`timescale 1ns/1ps

module i2c_sensor_model (
	input  logic clk,
	input  logic rst,
	input  logic scl,
	input  logic sda,	// Resolved line
	output logic sda_drive,	// High pulls SDA low
	output logic protocol_error
);
	import sensor_pkg::*;

	logic [15:0] value [NUM_SENSORS];	// Value answered per sensor
	logic        present [NUM_SENSORS];
	logic [15:0] sent [NUM_SENSORS];	// Last value actually sent
	int          xfer_count;	// Transactions ended by STOP
	logic        in_xfer;
	logic [4:0]  rise_cnt;	// SCL rises since START
	logic        scl_q;
	logic        sda_q;
	logic [6:0]  addr_sr;
	sensor_id_t  next_idx;	// Expected table position
	logic        cur_present;
	logic [15:0] tx_sr;
	logic [7:0]  addr_byte;
	int          hit;
	int          bit_idx;

	task automatic set_sensor(input int idx, input logic [15:0] v, input logic pres);
		value[idx]   = v;
		present[idx] = pres;
	endtask

	task automatic flag_violation(input string msg);
		$display("sensor model: %s", msg);
		protocol_error <= 1'b1;
	endtask

	// Lines are oversampled on clk so simultaneous SCL and SDA moves stay ordered
	always @(posedge clk)
	begin
		if (rst)
		begin
			scl_q          <= 1'b1;
			sda_q          <= 1'b1;
			in_xfer        <= 1'b0;
			rise_cnt       <= '0;
			sda_drive      <= 1'b0;
			protocol_error <= 1'b0;
			next_idx       <= '0;
			cur_present    <= 1'b0;
			xfer_count     <= 0;
			for (int i = 0; i < NUM_SENSORS; i++)
				sent[i] <= '0;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl_q && scl && sda_q && !sda)
			begin
				if (in_xfer)
					flag_violation("START inside a transaction");
				in_xfer   <= 1'b1;
				rise_cnt  <= '0;
				sda_drive <= 1'b0;
			end
			else if (scl_q && scl && !sda_q && sda)
			begin
				if (!in_xfer)
					flag_violation("STOP without a START");
				else if (rise_cnt != (cur_present ? 5'd28 : 5'd10))
					flag_violation($sformatf("STOP after %0d clock pulses", rise_cnt));
				in_xfer    <= 1'b0;
				sda_drive  <= 1'b0;
				xfer_count <= xfer_count + 1;
			end
			else if (in_xfer && !scl_q && scl)
			begin
				rise_cnt <= rise_cnt + 1'b1;
				if (rise_cnt < 5'd7)
					addr_sr <= {addr_sr[5:0], sda};
				if (rise_cnt == 5'd7)
				begin
					addr_byte = {addr_sr, sda};
					hit = -1;
					for (int i = 0; i < NUM_SENSORS; i++)
						if (SENSOR_ADDR[i] == addr_byte[7:1])
							hit = i;
					if (hit < 0)
						flag_violation($sformatf("read of unknown address %h", addr_byte[7:1]));
					else if (!addr_byte[0])
						flag_violation("address sent without the read bit");
					else if (hit != int'(next_idx))
						flag_violation($sformatf("sensor %0d read out of order", hit));
					else
					begin
						cur_present <= present[hit];
						tx_sr       <= value[hit];
						if (present[hit])
							sent[hit] <= value[hit];
					end
					next_idx <= next_idx + 1'b1;	// Wraps west to solar
				end
				if (cur_present && rise_cnt == 5'd17 && sda)
					flag_violation("master did not ACK the first byte");
				if (cur_present && rise_cnt == 5'd26 && !sda)
					flag_violation("master did not NACK the last byte");
			end
			else if (in_xfer && scl_q && !scl)
			begin
				// Next bit goes out while SCL is low
				if (rise_cnt == 5'd8)
					sda_drive <= cur_present;	// Address ACK
				else if (rise_cnt >= 5'd9 && rise_cnt <= 5'd16)
				begin
					bit_idx = 24 - int'(rise_cnt);
					sda_drive <= cur_present && !tx_sr[bit_idx[3:0]];
				end
				else if (rise_cnt >= 5'd18 && rise_cnt <= 5'd25)
				begin
					bit_idx = 25 - int'(rise_cnt);
					sda_drive <= cur_present && !tx_sr[bit_idx[3:0]];
				end
				else
					sda_drive <= 1'b0;
			end
		end
	end
endmodule

//--- tb/sensor_hub_tb.sv
`timescale 1ns/1ps

module sensor_hub_tb;
	localparam int CLK_DIV     = 2;
	localparam int READ_CYCLES = 29 * 2 * CLK_DIV + 4;	// Bits plus handshake slack
	localparam int LIMIT       = 4 * 6 * 8 * READ_CYCLES;

	logic              clk;
	logic              rst;
	logic              scl;
	logic              sda_oe;
	logic              model_drive;
	logic              model_error;
	logic              sda_line;
	logic signed [8:0] temp_out [4];
	logic [15:0]       lux_out [4];
	logic [8:0]        temp_prev [4];
	logic [15:0]       lux_prev [4];
	int                seed;
	int                cycle_count = 0;
	string temp_names [4] = '{"solar_celsius", "greenhouse_celsius",
		"ambient_celsius", "geothermal_celsius"};
	string lux_names [4] = '{"north_lux", "east_lux", "south_lux", "west_lux"};

	assign sda_line = ~(sda_oe | model_drive);	// Open-drain wired AND

	tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(2)) clock_gen_i (.clk(clk), .rst(rst));

	i2c_sensor_model sensor_model_i (
		.clk            (clk),
		.rst            (rst),
		.scl            (scl),
		.sda            (sda_line),
		.sda_drive      (model_drive),
		.protocol_error (model_error)
	);

	sensor_hub #(.CLK_DIV(CLK_DIV), .FIFO_DEPTH(4)) sensor_hub_i (
		.clk                (clk),
		.rst                (rst),
		.sda_in             (sda_line),
		.scl                (scl),
		.sda_oe             (sda_oe),
		.solar_celsius      (temp_out[0]),
		.greenhouse_celsius (temp_out[1]),
		.ambient_celsius    (temp_out[2]),
		.geothermal_celsius (temp_out[3]),
		.north_lux          (lux_out[0]),
		.east_lux           (lux_out[1]),
		.south_lux          (lux_out[2]),
		.west_lux           (lux_out[3])
	);

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic expect_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		a_value: assert (got === expected)
		else
			report_failure($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, expected));
	endtask

	// Fraction times two to the exponent, over 100, clipped at 16 bits
	function automatic logic [15:0] lux_expected(input logic [15:0] v);
		logic [31:0] full_val;
		full_val = ({20'd0, v[11:0]} << v[15:12]) / 32'd100;
		return (full_val > 32'd65535) ? 16'hffff : full_val[15:0];
	endfunction

	task automatic load_phase_values(input int phase);
		logic [15:0] v;
		for (int i = 0; i < 8; i++)
		begin
			v = 16'($random(seed));
			sensor_model_i.set_sensor(i, v, 1'b1);
		end
		case (phase)
			0:
			begin
				sensor_model_i.set_sensor(0, sensor_model_i.value[0] | 16'h8000, 1'b1);
				sensor_model_i.set_sensor(4, {4'h0, 12'd57}, 1'b1);	// Truncates to zero
				sensor_model_i.set_sensor(5, {4'hf, 12'hfff}, 1'b1);	// Saturates
			end
			1:
			begin
				sensor_model_i.set_sensor(3, sensor_model_i.value[3], 1'b0);
				sensor_model_i.set_sensor(6, sensor_model_i.value[6], 1'b0);
				sensor_model_i.set_sensor(2, sensor_model_i.value[2] | 16'h8000, 1'b1);
				sensor_model_i.set_sensor(7, {4'hf, 12'h123}, 1'b1);
				sensor_model_i.set_sensor(4, {4'h0, 12'd999}, 1'b1);
			end
			default:
			begin
				sensor_model_i.set_sensor(1, sensor_model_i.value[1] | 16'h8000, 1'b1);
				sensor_model_i.set_sensor(6, {4'h0, 12'd99}, 1'b1);
				sensor_model_i.set_sensor(5, {4'hf, 12'd150}, 1'b1);
			end
		endcase
	endtask

	// Waits until a read is mid-address so no sample is latched or in the pipeline
	task automatic wait_for_quiet_point();
		while (sensor_model_i.in_xfer)
			@(negedge clk);
		while (!(sensor_model_i.in_xfer && sensor_model_i.rise_cnt == 5'd4))
			@(negedge clk);
	endtask

	task automatic wait_reads(input int n);
		int target;
		target = sensor_model_i.xfer_count + n;
		while (sensor_model_i.xfer_count < target)
			@(negedge clk);
	endtask

	task automatic check_phase_end();
		for (int i = 0; i < 4; i++)
		begin
			if (sensor_model_i.present[i])
				expect_value(temp_names[i], {7'd0, temp_out[i]},
					{7'd0, sensor_model_i.value[i][15:7]});
			if (sensor_model_i.present[i + 4])
				expect_value(lux_names[i], lux_out[i],
					lux_expected(sensor_model_i.value[i + 4]));
		end
	endtask

	// Every reading change must match what the model last sent
	always @(negedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (temp_out[i] !== temp_prev[i])
				begin
					assert (sensor_model_i.present[i])
					else
						report_failure($sformatf("%s changed while absent", temp_names[i]));
					expect_value(temp_names[i], {7'd0, temp_out[i]},
						{7'd0, sensor_model_i.sent[i][15:7]});
				end
				if (lux_out[i] !== lux_prev[i])
				begin
					assert (sensor_model_i.present[i + 4])
					else
						report_failure($sformatf("%s changed while absent", lux_names[i]));
					expect_value(lux_names[i], lux_out[i],
						lux_expected(sensor_model_i.sent[i + 4]));
				end
			end
		end
		for (int i = 0; i < 4; i++)
		begin
			temp_prev[i] = temp_out[i];
			lux_prev[i]  = lux_out[i];
		end
	end

	always @(negedge clk)
	begin
		if (!rst)
		begin
			a_protocol_ok: assert (!model_error)
			else
				report_failure("The sensor model saw a bus protocol violation");
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= LIMIT)
			report_failure("Timeout: the polling sweeps did not finish in time");
	end

	initial
	begin
		seed = 32'h2bd3535b;
		load_phase_values(0);
		@(negedge clk);
		while (rst)
			@(negedge clk);

		a_reset_scl: assert (scl === 1'b1)
		else
			report_failure($sformatf("[FAIL] scl got 0x%h expected 0x1", scl));
		a_reset_sda: assert (sda_oe === 1'b0)
		else
			report_failure($sformatf("[FAIL] sda_oe got 0x%h expected 0x0", sda_oe));
		for (int i = 0; i < 4; i++)
		begin
			expect_value(temp_names[i], {7'd0, temp_out[i]}, 16'h0000);
			expect_value(lux_names[i], lux_out[i], 16'h0000);
		end

		for (int phase = 0; phase < 3; phase++)
		begin
			if (phase > 0)
			begin
				wait_for_quiet_point();
				load_phase_values(phase);
			end
			wait_reads(17);	// Two sweeps plus the read that drains the pipeline
			check_phase_end();
		end

		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

//--- filelist.f
verilog/sensor_pkg.sv
verilog/i2c_req_if.sv
verilog/poll_sequencer.sv
verilog/i2c_master.sv
verilog/sample_fifo.sv
verilog/reading_decoder.sv
verilog/sensor_hub.sv
tb/tb_clock_gen.sv
tb/i2c_sensor_model.sv
tb/sensor_hub_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := sensor_hub_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
